// ==== source/burst_map_settings.svh ====
`ifndef BURST_MAP_SETTINGS_SVH
`define BURST_MAP_SETTINGS_SVH

// Line address and data beat widths, shared by master and slave
`define ADDR_WIDTH 16
`define DATA_WIDTH 64

// Master bursts run from 1 to 64 beats and slave bursts from 1 to 4 beats
`define M_BURST_WIDTH 7
`define S_BURST_WIDTH 3

// Nonzero forces power-of-two slave bursts aligned to their own length
`define NATURAL_ALIGNMENT 1
// Slave write bursts that may wait for a response at one time
`define RESP_QUEUE_DEPTH 16

`endif

// ==== source/burst_map_pkg.sv ====
`include "burst_map_settings.svh"

package burst_map_pkg;

    // Request from the master, with a burst count of up to 64 beats
    typedef struct packed {
        logic [`ADDR_WIDTH-1:0]    address;
        logic [`M_BURST_WIDTH-1:0] burstcount;
    } m_req_t;

    // Request to the slave, never longer than 4 beats
    typedef struct packed {
        logic [`ADDR_WIDTH-1:0]    address;
        logic [`S_BURST_WIDTH-1:0] burstcount;
    } s_req_t;

    // One write beat with its byte mask
    typedef struct packed {
        logic [`DATA_WIDTH-1:0]   data;
        logic [`DATA_WIDTH/8-1:0] byteenable;
    } wr_beat_t;

    // One read beat; response is passed on as the slave gives it
    typedef struct packed {
        logic [`DATA_WIDTH-1:0] data;
        logic [1:0]             response;
    } rd_rsp_t;

    // GB_SPLIT means a master burst still has slave bursts to issue
    typedef enum logic {
        GB_IDLE,
        GB_SPLIT
    } gb_state_t;

endpackage

// ==== source/burst_map_sop_tracker.sv ====
`timescale 1ns/10ps

module burst_map_sop_tracker
#(
    parameter BURST_CNT_WIDTH = 7
)
(
    input  logic                       clk,
    input  logic                       reset,
    input  logic                       flit_valid,
    input  logic [BURST_CNT_WIDTH-1:0] burstcount,
    output logic                       sop,
    output logic                       eop
);

    // Beats still expected in the current burst, zero between bursts
    logic [BURST_CNT_WIDTH-1:0] beats_left;

    // Any flit seen while no burst is open starts a new one
    assign sop = (beats_left == '0);

    // A single-beat burst is its own last beat
    assign eop = sop ? (burstcount == BURST_CNT_WIDTH'(1)) :
                       (beats_left == BURST_CNT_WIDTH'(1));

    always_ff @(posedge clk)
    begin
        if (reset)
            beats_left <= '0;
        else if (flit_valid)
        begin
            // The burst count is only meaningful on the SOP flit
            if (sop)
                beats_left <= burstcount - 1'b1;
            else
                beats_left <= beats_left - 1'b1;
        end
    end

endmodule

// ==== source/burst_map_gearbox.sv ====
`timescale 1ns/10ps
`include "burst_map_settings.svh"

module burst_map_gearbox
#(
    parameter NATURAL_ALIGNMENT = `NATURAL_ALIGNMENT
)
(
    input  logic                  clk,
    input  logic                  reset,
    input  logic                  new_req,
    input  burst_map_pkg::m_req_t m_req,
    input  logic                  accept,
    output logic                  complete,
    output burst_map_pkg::s_req_t s_req
);
    import burst_map_pkg::*;

    localparam int AW = `ADDR_WIDTH;
    localparam int MW = `M_BURST_WIDTH;
    localparam int SW = `S_BURST_WIDTH;
    // Longest burst the slave accepts
    localparam int S_MAX = 1 << (SW - 1);

    gb_state_t     state;
    logic [AW-1:0] next_addr;
    logic [MW-1:0] remaining;
    logic [SW-1:0] len;
    logic          last_burst;

    // Pick the length of the slave burst at next_addr
    always_comb
    begin
        if (NATURAL_ALIGNMENT == 0)
        begin
            // Unaligned slaves take any length up to their limit
            if (remaining > MW'(S_MAX))
                len = SW'(S_MAX);
            else
                len = remaining[SW-1:0];
        end
        else
        begin
            // Grow through the powers of two while the address stays aligned
            // and enough beats remain, so the last match is the largest
            len = SW'(1);
            for (int i = 1; i < SW; i++)
            begin
                if ((remaining >= MW'(1 << i)) &&
                    ((next_addr & AW'((1 << i) - 1)) == '0))
                    len = SW'(1 << i);
            end
        end
    end

    // The current slave burst uses up every remaining beat
    assign last_burst = (remaining == MW'(len));
    assign complete   = accept && (state == GB_SPLIT) && last_burst;

    assign s_req.address    = next_addr;
    assign s_req.burstcount = len;

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            state     <= GB_IDLE;
            remaining <= '0;
        end
        else if (new_req)
        begin
            // A new master burst wins over finishing the old one
            state     <= GB_SPLIT;
            remaining <= m_req.burstcount;
        end
        else if (accept && (state == GB_SPLIT))
        begin
            remaining <= remaining - MW'(len);
            if (last_burst)
                state <= GB_IDLE;
        end
    end

    // Address is payload and follows the same load and advance rules
    always_ff @(posedge clk)
    begin
        if (new_req)
            next_addr <= m_req.address;
        else if (accept && (state == GB_SPLIT))
            next_addr <= next_addr + AW'(len);
    end

endmodule

// ==== source/burst_map_rdwr.sv ====
`timescale 1ns/10ps
`include "burst_map_settings.svh"

module burst_map_rdwr
(
    input  logic                    clk,
    input  logic                    reset,

    input  logic                    m_rd_read,
    input  burst_map_pkg::m_req_t   m_rd_req,
    output logic                    m_rd_waitrequest,
    input  logic                    m_wr_write,
    input  burst_map_pkg::m_req_t   m_wr_req,
    input  burst_map_pkg::wr_beat_t m_wr_beat,
    output logic                    m_wr_waitrequest,

    output logic                    s_rd_read,
    output burst_map_pkg::s_req_t   s_rd_req,
    input  logic                    s_rd_waitrequest,
    output logic                    s_wr_write,
    output burst_map_pkg::s_req_t   s_wr_req,
    output burst_map_pkg::wr_beat_t s_wr_beat,
    input  logic                    s_wr_waitrequest,

    input  logic                    queue_full,
    output logic                    sop_push,
    output logic                    expects_rsp
);

    logic rd_next;
    logic rd_complete;
    logic wr_complete;
    logic m_wr_accept;
    logic s_wr_accept;
    logic m_wr_sop;
    logic s_wr_sop;

    // A new master read is taken once the slave port is free and the
    // previous split, if any, hands over its last slave burst
    assign rd_next          = !s_rd_waitrequest && (!s_rd_read || rd_complete);
    assign m_rd_waitrequest = !rd_next;

    burst_map_gearbox rd_gearbox
    (
        .clk      (clk),
        .reset    (reset),
        .new_req  (rd_next && m_rd_read),
        .m_req    (m_rd_req),
        .accept   (s_rd_read && !s_rd_waitrequest),
        .complete (rd_complete),
        .s_req    (s_rd_req)
    );

    // The read level stays up across all slave bursts of one master burst
    always_ff @(posedge clk)
    begin
        if (reset)
            s_rd_read <= 1'b0;
        else if (rd_next)
            s_rd_read <= m_rd_read;
    end

    // A nearly full response queue blocks the master like a busy slave
    assign m_wr_waitrequest = s_wr_waitrequest || queue_full;
    assign m_wr_accept      = m_wr_write && !m_wr_waitrequest;
    assign s_wr_accept      = s_wr_write && !s_wr_waitrequest;

    // Only SOP beats carry a request, so the gearbox moves on SOPs alone
    burst_map_gearbox wr_gearbox
    (
        .clk      (clk),
        .reset    (reset),
        .new_req  (m_wr_accept && m_wr_sop),
        .m_req    (m_wr_req),
        .accept   (s_wr_accept && s_wr_sop),
        .complete (wr_complete),
        .s_req    (s_wr_req)
    );

    // Each beat moves to the slave one cycle after the master hands it over
    always_ff @(posedge clk)
    begin
        if (reset)
            s_wr_write <= 1'b0;
        else if (!s_wr_waitrequest)
            s_wr_write <= m_wr_accept;
    end

    always_ff @(posedge clk)
    begin
        if (!s_wr_waitrequest)
            s_wr_beat <= m_wr_beat;
    end

    burst_map_sop_tracker #(.BURST_CNT_WIDTH(`M_BURST_WIDTH)) m_sop_tracker
    (
        .clk        (clk),
        .reset      (reset),
        .flit_valid (m_wr_accept),
        .burstcount (m_wr_req.burstcount),
        .sop        (m_wr_sop),
        .eop        ()
    );

    burst_map_sop_tracker #(.BURST_CNT_WIDTH(`S_BURST_WIDTH)) s_sop_tracker
    (
        .clk        (clk),
        .reset      (reset),
        .flit_valid (s_wr_accept),
        .burstcount (s_wr_req.burstcount),
        .sop        (s_wr_sop),
        .eop        ()
    );

    // One flag per slave write burst, set when it closes its master burst
    assign sop_push    = s_wr_accept && s_wr_sop;
    assign expects_rsp = wr_complete;

endmodule

// ==== source/burst_map_wr_resp_filter.sv ====
`timescale 1ns/10ps
`include "burst_map_settings.svh"

module burst_map_wr_resp_filter
(
    input  logic       clk,
    input  logic       reset,
    input  logic       sop_push,
    input  logic       expects_rsp,
    output logic       queue_full,
    input  logic       s_wr_rsp_valid,
    input  logic [1:0] s_wr_rsp,
    output logic       m_wr_rsp_valid,
    output logic [1:0] m_wr_rsp
);

    localparam int DEPTH = `RESP_QUEUE_DEPTH;
    localparam int PW    = $clog2(DEPTH);
    localparam int CW    = PW + 1;

    // One flag per outstanding slave write burst, oldest at rd_ptr
    logic          flags [DEPTH];
    // Pointers carry an extra wrap bit so full and empty differ
    logic [PW:0]   wr_ptr;
    logic [PW:0]   rd_ptr;
    logic [PW:0]   used;

    assign used = wr_ptr - rd_ptr;

    // Full one entry early since a beat already taken from the master
    // may still push its SOP flag a cycle later
    assign queue_full = (used >= CW'(DEPTH - 1));

    always_ff @(posedge clk)
    begin
        if (sop_push)
            flags[wr_ptr[PW-1:0]] <= expects_rsp;
    end

    // Every slave response retires exactly one flag
    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            wr_ptr <= '0;
            rd_ptr <= '0;
        end
        else
        begin
            if (sop_push)
                wr_ptr <= wr_ptr + 1'b1;
            if (s_wr_rsp_valid)
                rd_ptr <= rd_ptr + 1'b1;
        end
    end

    // Only the final slave burst of a master burst answers the master
    assign m_wr_rsp_valid = s_wr_rsp_valid && flags[rd_ptr[PW-1:0]];
    assign m_wr_rsp       = s_wr_rsp;

endmodule

// ==== source/burst_map_top.sv ====
`timescale 1ns/10ps

module burst_map_top
(
    input  logic                    clk,
    input  logic                    reset,

    input  logic                    m_rd_read,
    input  burst_map_pkg::m_req_t   m_rd_req,
    output logic                    m_rd_waitrequest,
    output logic                    m_rd_valid,
    output burst_map_pkg::rd_rsp_t  m_rd_rsp,
    input  logic                    m_wr_write,
    input  burst_map_pkg::m_req_t   m_wr_req,
    input  burst_map_pkg::wr_beat_t m_wr_beat,
    output logic                    m_wr_waitrequest,
    output logic                    m_wr_rsp_valid,
    output logic [1:0]              m_wr_rsp,

    output logic                    s_rd_read,
    output burst_map_pkg::s_req_t   s_rd_req,
    input  logic                    s_rd_waitrequest,
    input  logic                    s_rd_valid,
    input  burst_map_pkg::rd_rsp_t  s_rd_rsp,
    output logic                    s_wr_write,
    output burst_map_pkg::s_req_t   s_wr_req,
    output burst_map_pkg::wr_beat_t s_wr_beat,
    input  logic                    s_wr_waitrequest,
    input  logic                    s_wr_rsp_valid,
    input  logic [1:0]              s_wr_rsp
);

    logic sop_push;
    logic expects_rsp;
    logic queue_full;

    // Read beats carry no burst framing and go straight to the master
    assign m_rd_valid = s_rd_valid;
    assign m_rd_rsp   = s_rd_rsp;

    burst_map_rdwr mapper
    (
        .clk              (clk),
        .reset            (reset),
        .m_rd_read        (m_rd_read),
        .m_rd_req         (m_rd_req),
        .m_rd_waitrequest (m_rd_waitrequest),
        .m_wr_write       (m_wr_write),
        .m_wr_req         (m_wr_req),
        .m_wr_beat        (m_wr_beat),
        .m_wr_waitrequest (m_wr_waitrequest),
        .s_rd_read        (s_rd_read),
        .s_rd_req         (s_rd_req),
        .s_rd_waitrequest (s_rd_waitrequest),
        .s_wr_write       (s_wr_write),
        .s_wr_req         (s_wr_req),
        .s_wr_beat        (s_wr_beat),
        .s_wr_waitrequest (s_wr_waitrequest),
        .queue_full       (queue_full),
        .sop_push         (sop_push),
        .expects_rsp      (expects_rsp)
    );

    // Collapses slave write responses to one per master burst
    burst_map_wr_resp_filter resp_filter
    (
        .clk            (clk),
        .reset          (reset),
        .sop_push       (sop_push),
        .expects_rsp    (expects_rsp),
        .queue_full     (queue_full),
        .s_wr_rsp_valid (s_wr_rsp_valid),
        .s_wr_rsp       (s_wr_rsp),
        .m_wr_rsp_valid (m_wr_rsp_valid),
        .m_wr_rsp       (m_wr_rsp)
    );

endmodule

// ==== verif/burst_map_clock.sv ====
`timescale 1ns/10ps

module burst_map_clock
#(
    parameter PERIOD = 20
)
(
    output logic clk
);

    // Free-running clock, low for the first half period
    initial
    begin
        clk = 1'b0;
    end

    always #(PERIOD / 2) clk = ~clk;

endmodule

// ==== verif/burst_map_props.sv ====
`timescale 1ns/10ps
`include "burst_map_settings.svh"

module burst_map_props
#(
    parameter ALIGN = `NATURAL_ALIGNMENT
)
(
    input  logic                      clk,
    input  logic                      reset,
    input  logic                      req_valid,
    input  burst_map_pkg::s_req_t     s_req,
    input  logic                      m_beat_accept,
    input  logic [`M_BURST_WIDTH-1:0] m_burstcount,
    input  logic                      rsp_valid
);
    import burst_map_pkg::*;

    logic [`M_BURST_WIDTH-1:0] beats_left;
    int                        bursts;
    int                        rsps;

    // Own count of master write bursts, taken from the SOP beats
    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            beats_left <= '0;
            bursts     <= 0;
            rsps       <= 0;
        end
        else
        begin
            if (m_beat_accept)
            begin
                if (beats_left == '0)
                begin
                    beats_left <= m_burstcount - 1'b1;
                    bursts     <= bursts + 1;
                end
                else
                    beats_left <= beats_left - 1'b1;
            end
            if (rsp_valid)
                rsps <= rsps + 1;
        end
    end

    // A slave burst holds 1 to 4 beats
    a_len: assert property (@(posedge clk) disable iff (reset)
        req_valid |-> (s_req.burstcount != '0) && (s_req.burstcount <= 3'd4))
        else $error("slave burst count out of range");

    // An aligned burst starts on a multiple of its own length
    a_align: assert property (@(posedge clk) disable iff (reset)
        (req_valid && (ALIGN != 0)) |->
        ((s_req.address & `ADDR_WIDTH'(s_req.burstcount - 1'b1)) == '0))
        else $error("slave burst address not aligned to its length");

    // A write response never runs ahead of the master bursts
    a_rsp: assert property (@(posedge clk) disable iff (reset)
        rsp_valid |-> (rsps < bursts))
        else $error("more write responses than master write bursts");

endmodule

bind burst_map_gearbox burst_map_props gearbox_props
(
    .clk           (clk),
    .reset         (reset),
    .req_valid     (state == burst_map_pkg::GB_SPLIT),
    .s_req         (s_req),
    .m_beat_accept (1'b0),
    .m_burstcount  (`M_BURST_WIDTH'(1)),
    .rsp_valid     (1'b0)
);

bind burst_map_top burst_map_props top_props
(
    .clk           (clk),
    .reset         (reset),
    .req_valid     (s_rd_read),
    .s_req         (s_rd_req),
    .m_beat_accept (m_wr_write && !m_wr_waitrequest),
    .m_burstcount  (m_wr_req.burstcount),
    .rsp_valid     (m_wr_rsp_valid)
);

// ==== verif/burst_map_tb.sv ====
`timescale 1ns/10ps
`include "burst_map_settings.svh"

module burst_map_tb;
    import burst_map_pkg::*;

    typedef enum logic {
        OP_READ,
        OP_WRITE
    } op_t;

    localparam int AW        = `ADDR_WIDTH;
    localparam int DW        = `DATA_WIDTH;
    localparam int SW        = `S_BURST_WIDTH;
    localparam int MAX_TESTS = 64;

    // One expected slave burst, with a flag for the last one of its master burst
    typedef struct packed {
        logic [AW-1:0] address;
        logic [SW-1:0] len;
        logic          final_burst;
    } split_t;

    logic     clk;
    logic     reset;
    logic     m_rd_read;
    m_req_t   m_rd_req;
    logic     m_rd_waitrequest;
    logic     m_rd_valid;
    rd_rsp_t  m_rd_rsp;
    logic     m_wr_write;
    m_req_t   m_wr_req;
    wr_beat_t m_wr_beat;
    logic     m_wr_waitrequest;
    logic     m_wr_rsp_valid;
    logic [1:0] m_wr_rsp;
    logic     s_rd_read;
    s_req_t   s_rd_req;
    logic     s_rd_waitrequest;
    logic     s_rd_valid;
    rd_rsp_t  s_rd_rsp;
    logic     s_wr_write;
    s_req_t   s_wr_req;
    wr_beat_t s_wr_beat;
    logic     s_wr_waitrequest;
    logic     s_wr_rsp_valid;
    logic [1:0] s_wr_rsp;

    logic [31:0]   test_words [MAX_TESTS*4];
    int            num_tests;
    int            error_count;
    logic          started;
    // Slave memory and the memory as the master has written it
    logic [DW-1:0] mem [1<<AW];
    logic [DW-1:0] ref_mem [1<<AW];
    split_t        exp_rd_q [$];
    split_t        exp_wr_q [$];
    logic [DW-1:0] exp_data_q [$];
    logic [DW-1:0] rd_data_q [$];
    int            rd_delay_q [$];
    int            wr_rsp_delay_q [$];
    logic          wr_rsp_final_q [$];
    logic          cur_rsp_final;
    logic [1:0]    cur_rsp_code;
    int            wr_rsp_seen;
    int            wr_rsp_target;
    int            s_wr_left;
    logic [AW-1:0] s_wr_addr;

    burst_map_clock #(.PERIOD(20)) clock_gen (.clk(clk));

    burst_map_top dut0
    (
        .clk              (clk),
        .reset            (reset),
        .m_rd_read        (m_rd_read),
        .m_rd_req         (m_rd_req),
        .m_rd_waitrequest (m_rd_waitrequest),
        .m_rd_valid       (m_rd_valid),
        .m_rd_rsp         (m_rd_rsp),
        .m_wr_write       (m_wr_write),
        .m_wr_req         (m_wr_req),
        .m_wr_beat        (m_wr_beat),
        .m_wr_waitrequest (m_wr_waitrequest),
        .m_wr_rsp_valid   (m_wr_rsp_valid),
        .m_wr_rsp         (m_wr_rsp),
        .s_rd_read        (s_rd_read),
        .s_rd_req         (s_rd_req),
        .s_rd_waitrequest (s_rd_waitrequest),
        .s_rd_valid       (s_rd_valid),
        .s_rd_rsp         (s_rd_rsp),
        .s_wr_write       (s_wr_write),
        .s_wr_req         (s_wr_req),
        .s_wr_beat        (s_wr_beat),
        .s_wr_waitrequest (s_wr_waitrequest),
        .s_wr_rsp_valid   (s_wr_rsp_valid),
        .s_wr_rsp         (s_wr_rsp)
    );

    task automatic report_mismatch(input string msg);
        error_count++;
        $display("Fail at %0t ns: %s", $time, msg);
        $display("Simulation failed");
        $fatal(1, "stopped at the first mismatch");
    endtask

    task automatic report_error(input string msg);
        error_count++;
        $display("Error: %s", msg);
        $display("Simulation failed");
        $fatal(1, "stopped at the first error");
    endtask

    // Initial memory word, a mix of every address bit
    function automatic logic [DW-1:0] fill_word(input logic [AW-1:0] a);
        return {16'h5a00 ^ {a[7:0], a[15:8]}, a, ~a, a ^ 16'hc3a5};
    endfunction

    function automatic logic [DW-1:0] beat_data(input logic [31:0] seed, input int i);
        return {seed ^ 32'(i * 32'h01000193), ~seed ^ 32'(i)};
    endfunction

    function automatic logic [7:0] beat_mask(input logic [31:0] seed, input int i);
        return seed[31] ? (seed[7:0] ^ 8'(i)) : 8'hff;
    endfunction

    // Merges the enabled bytes of a beat into a stored word
    function automatic logic [DW-1:0] apply_mask(input logic [DW-1:0] old,
                                                 input logic [DW-1:0] data,
                                                 input logic [7:0] mask);
        logic [DW-1:0] w;
        w = old;
        for (int b = 0; b < DW / 8; b++)
        begin
            if (mask[b])
                w[b*8 +: 8] = data[b*8 +: 8];
        end
        return w;
    endfunction

    // Longest legal burst at each address, then the address moves on
    task automatic push_split(input op_t op, input logic [AW-1:0] addr, input int n);
        split_t e;
        int     len;
        while (n > 0)
        begin
            if (`NATURAL_ALIGNMENT != 0)
            begin
                len = 1;
                if ((n >= 2) && (addr[0] == 1'b0))
                    len = 2;
                if ((n >= 4) && (addr[1:0] == 2'b00))
                    len = 4;
            end
            else
                len = (n > 4) ? 4 : n;
            e.address     = addr;
            e.len         = SW'(len);
            e.final_burst = (n == len);
            if (op == OP_READ)
                exp_rd_q.push_back(e);
            else
                exp_wr_q.push_back(e);
            addr = AW'(addr + len);
            n    = n - len;
        end
    endtask

    task automatic run_test(input op_t op, input logic [AW-1:0] addr, input int n,
                            input logic [31:0] seed);
        logic [AW-1:0] a;
        wr_beat_t      b;
        push_split(op, addr, n);
        if (op == OP_READ)
        begin
            for (int i = 0; i < n; i++)
            begin
                a = AW'(addr + i);
                exp_data_q.push_back(ref_mem[a]);
            end
            @(posedge clk);
            #1;
            m_rd_read           = 1'b1;
            m_rd_req.address    = addr;
            m_rd_req.burstcount = `M_BURST_WIDTH'(n);
            @(negedge clk);
            while (m_rd_waitrequest)
                @(negedge clk);
            @(posedge clk);
            #1;
            m_rd_read = 1'b0;
            while ((exp_data_q.size() > 0) || (exp_rd_q.size() > 0))
                @(negedge clk);
        end
        else
        begin
            wr_rsp_target++;
            for (int i = 0; i < n; i++)
            begin
                @(posedge clk);
                #1;
                b.data              = beat_data(seed, i);
                b.byteenable        = beat_mask(seed, i);
                m_wr_write          = 1'b1;
                m_wr_req.address    = addr;
                m_wr_req.burstcount = `M_BURST_WIDTH'(n);
                m_wr_beat           = b;
                @(negedge clk);
                while (m_wr_waitrequest)
                    @(negedge clk);
                a          = AW'(addr + i);
                ref_mem[a] = apply_mask(ref_mem[a], b.data, b.byteenable);
            end
            @(posedge clk);
            #1;
            m_wr_write = 1'b0;
            while ((wr_rsp_seen < wr_rsp_target) || (exp_wr_q.size() > 0))
                @(negedge clk);
        end
    endtask

    // Slave side drive: random waitrequest and the queued responses
    always @(posedge clk)
    begin
        #1;
        s_rd_waitrequest = (($urandom % 4) == 0);
        s_wr_waitrequest = (($urandom % 4) == 0);
        s_rd_valid       = 1'b0;
        s_wr_rsp_valid   = 1'b0;
        if (!reset && (rd_data_q.size() > 0))
        begin
            if (rd_delay_q[0] > 0)
                rd_delay_q[0] = rd_delay_q[0] - 1;
            else
            begin
                s_rd_valid = 1'b1;
                s_rd_rsp   = {rd_data_q.pop_front(), 2'b00};
                void'(rd_delay_q.pop_front());
            end
        end
        // Write responses wait while a beat is on the port, so a long burst
        // runs the response queue up to full
        if (!reset && !s_wr_write && (wr_rsp_delay_q.size() > 0))
        begin
            if (wr_rsp_delay_q[0] > 0)
                wr_rsp_delay_q[0] = wr_rsp_delay_q[0] - 1;
            else
            begin
                s_wr_rsp_valid = 1'b1;
                s_wr_rsp       = 2'($urandom % 4);
                cur_rsp_code   = s_wr_rsp;
                cur_rsp_final  = wr_rsp_final_q.pop_front();
                void'(wr_rsp_delay_q.pop_front());
            end
        end
    end

    // Slave model and master checks, sampled in the middle of the cycle
    always @(negedge clk)
    begin
        split_t e;
        logic [DW-1:0] d;
        if (!reset)
        begin
            if (!started)
                assert (!s_rd_read && !s_wr_write && !m_rd_valid && !m_wr_rsp_valid)
                else report_mismatch("output active before the first test");
            if (s_rd_read && !s_rd_waitrequest)
            begin
                assert (exp_rd_q.size() > 0)
                else report_error("slave read burst with none expected");
                e = exp_rd_q.pop_front();
                assert ((s_rd_req.address == e.address) && (s_rd_req.burstcount == e.len))
                else report_mismatch($sformatf("slave read burst %h/%0d, expected %h/%0d",
                    s_rd_req.address, s_rd_req.burstcount, e.address, e.len));
                for (int j = 0; j < int'(e.len); j++)
                begin
                    rd_data_q.push_back(mem[AW'(e.address + j)]);
                    rd_delay_q.push_back((j == 0) ? int'(1 + $urandom % 3) : 0);
                end
            end
            if (s_wr_write && !s_wr_waitrequest)
            begin
                if (s_wr_left == 0)
                begin
                    assert (exp_wr_q.size() > 0)
                    else report_error("slave write burst with none expected");
                    e = exp_wr_q.pop_front();
                    assert ((s_wr_req.address == e.address) &&
                            (s_wr_req.burstcount == e.len))
                    else report_mismatch($sformatf("slave write burst %h/%0d, expected %h/%0d",
                        s_wr_req.address, s_wr_req.burstcount, e.address, e.len));
                    s_wr_left = int'(e.len);
                    s_wr_addr = e.address;
                    wr_rsp_final_q.push_back(e.final_burst);
                end
                mem[s_wr_addr] = apply_mask(mem[s_wr_addr], s_wr_beat.data,
                                            s_wr_beat.byteenable);
                s_wr_addr = AW'(s_wr_addr + 1);
                s_wr_left = s_wr_left - 1;
                // One response per slave burst, once its last beat is in
                if (s_wr_left == 0)
                    wr_rsp_delay_q.push_back(int'(1 + $urandom % 3));
            end
            if (m_rd_valid)
            begin
                assert (exp_data_q.size() > 0)
                else report_error("read data returned with none outstanding");
                d = exp_data_q.pop_front();
                assert (m_rd_rsp == {d, 2'b00})
                else report_mismatch($sformatf("read data %h, expected %h",
                    m_rd_rsp.data, d));
            end
            // Only the final slave burst of a master burst is answered
            assert (m_wr_rsp_valid == (s_wr_rsp_valid && cur_rsp_final))
            else report_mismatch("write response to the master at the wrong time");
            if (m_wr_rsp_valid)
            begin
                // The response code is the one the slave gave
                assert (m_wr_rsp == cur_rsp_code)
                else report_mismatch($sformatf("write response code %0d, expected %0d",
                    m_wr_rsp, cur_rsp_code));
                wr_rsp_seen++;
            end
        end
    end

    // Watchdog sized from the number of test lines
    initial
    begin
        #1;
        repeat (num_tests * 200 + 20)
            @(posedge clk);
        $display("Error: the tests did not finish in time");
        $display("Simulation failed");
        $fatal(1, "watchdog expired");
    end

    initial
    begin
        void'($urandom(47));
        reset            = 1'b1;
        m_rd_read        = 1'b0;
        m_rd_req         = '0;
        m_wr_write       = 1'b0;
        m_wr_req         = '0;
        m_wr_beat        = '0;
        s_rd_waitrequest = 1'b0;
        s_rd_valid       = 1'b0;
        s_rd_rsp         = '0;
        s_wr_waitrequest = 1'b0;
        s_wr_rsp_valid   = 1'b0;
        s_wr_rsp         = 2'b00;
        cur_rsp_final    = 1'b0;
        cur_rsp_code     = 2'b00;
        started          = 1'b0;
        error_count      = 0;
        wr_rsp_seen      = 0;
        wr_rsp_target    = 0;
        s_wr_left        = 0;
        s_wr_addr        = '0;
        for (int a = 0; a < (1 << AW); a++)
        begin
            mem[a]     = fill_word(AW'(a));
            ref_mem[a] = mem[a];
        end
        for (int i = 0; i < MAX_TESTS * 4; i++)
            test_words[i] = 32'hffffffff;
        $readmemh("verif/burst_map_tests.txt", test_words);
        num_tests = 0;
        while ((num_tests < MAX_TESTS) && (test_words[num_tests*4] != 32'hffffffff))
            num_tests++;
        assert (num_tests > 0)
        else report_error("no test lines found in the test file");

        repeat (10)
            @(posedge clk);
        #1;
        reset = 1'b0;
        // Idle outputs are checked for a few cycles before any traffic
        repeat (3)
            @(negedge clk);
        started = 1'b1;

        for (int t = 0; t < num_tests; t++)
            run_test((test_words[t*4] != 0) ? OP_WRITE : OP_READ,
                     AW'(test_words[t*4+1]), int'(test_words[t*4+2]),
                     test_words[t*4+3]);

        repeat (5)
            @(negedge clk);
        assert ((wr_rsp_seen == wr_rsp_target) && (rd_data_q.size() == 0))
        else report_mismatch("responses left over after the last test");

        if (error_count == 0)
            $display("Simulation passed");
        else
            $display("Simulation failed");
        $finish;
    end

endmodule

// ==== burst_map_top.f ====
+incdir+source
source/burst_map_pkg.sv
source/burst_map_sop_tracker.sv
source/burst_map_gearbox.sv
source/burst_map_rdwr.sv
source/burst_map_wr_resp_filter.sv
source/burst_map_top.sv
verif/burst_map_clock.sv
verif/burst_map_props.sv
verif/burst_map_tb.sv

// ==== run_sim.sh ====
#!/bin/bash
# Builds the burst mapper testbench with Verilator and runs it.
# The result is taken from the pass line in the log.
set -e

cd "$(dirname "$0")"

rm -rf obj_dir sim.log

verilator --binary --timing --assert \
    -f burst_map_top.f \
    --top-module burst_map_tb \
    -o burst_map_sim

# The simulator exits nonzero on a failed check, and the log decides the result
./obj_dir/burst_map_sim > sim.log 2>&1 || true
cat sim.log

if grep -q "^Simulation passed$" sim.log; then
    exit 0
else
    exit 1
fi

// ==== verif/burst_map_tests.txt ====
// Columns: op (0 read, 1 write), start address, burst count, data seed
// Seed bit 31 set gives partial byte enables on the write beats
00000001 00000000 00000001 11111111
00000001 00000001 00000040 8abc0001
00000000 00000001 00000040 00000000
00000001 00000100 00000007 80000013
00000000 00000100 00000007 00000000
00000001 00000203 00000005 22220005
00000000 00000202 00000008 00000000
00000000 00000000 00000001 00000000
00000001 00000400 00000040 33330040
00000000 00000400 00000040 00000000
00000001 00001005 00000003 80000777
00000000 00001004 00000004 00000000
00000001 0000fffe 00000004 44444444
00000000 0000fffe 00000004 00000000
00000001 00000010 00000002 55550002
00000001 00000012 00000002 55550012
00000000 00000010 00000004 00000000
00000000 00002001 0000000f 00000000
00000001 00003007 00000009 80006666
00000000 00003006 0000000c 00000000
